//--- amigaBus.f
+incdir+tb
src/busPkg.sv
src/mapPkg.sv
src/addressDecode.sv
src/overlayControl.sv
src/ciaCycle.sv
src/cycleTerminator.sv
src/busCycleTop.sv
tb/busCycleTb.sv

//--- tb/busCycleChecks.svh
`ifndef BUS_CYCLE_CHECKS_SVH
`define BUS_CYCLE_CHECKS_SVH

// Termination kind as ta or tea
task automatic checkTerm(input termKind expected, input termKind actual);
    if (actual !== expected) begin
        $display("CHECK FAILED termKind in entry %0d: expected 0x%h, got 0x%h",
                 currentEntry, expected, actual);
        abortRun();
    end
endtask

// Strobes seen asserted from decode through the ending cycle
task automatic checkSelects(input busSelects expected, input busSelects actual);
    if (actual !== expected) begin
        $display("CHECK FAILED selects in entry %0d: expected 0x%h, got 0x%h",
                 currentEntry, expected, actual);
        abortRun();
    end
endtask

// Cycles from the ts cycle to the ta or tea cycle
task automatic checkLatency(input int expected, input int actual);
    if (actual != expected) begin
        $display("CHECK FAILED ta/tea latency in entry %0d: expected 0x%h, got 0x%h",
                 currentEntry, expected, actual);
        abortRun();
    end
endtask

// CIA cycles land somewhere inside one E period
task automatic checkLatencyWindow(input int low, input int high, input int actual);
    if ((actual < low) || (actual > high)) begin
        $display("CHECK FAILED ta latency in entry %0d: 0x%h outside 0x%h to 0x%h",
                 currentEntry, actual, low, high);
        abortRun();
    end
endtask

// E pin against the reference divider
task automatic checkEClock(input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("CHECK FAILED eClock at cycle %0d: expected 0x%h, got 0x%h",
                 cycleCount, expected, actual);
        abortRun();
    end
endtask

`endif

//--- tb/busCycleTb.sv
module busCycleTb;
    timeunit 1ns;
    timeprecision 100ps;

    import busPkg::*;
    import mapPkg::*;

    // Latency codes for cycles with no fixed length
    localparam int LAT_AGNUS = 0;
    localparam int LAT_CIA   = -1;
    localparam int CIA_MIN   = 5;
    localparam int CIA_MAX   = 14;

    typedef struct {
        busRequest request;
        termKind   expTerm;
        busSelects expSelects;
        int        expLatency;
    } testEntry;

    logic      bClk = 1'b0;
    logic      reset;
    logic      ts;
    busRequest request;
    logic      agnusAck;
    logic      ta;
    logic      tea;
    busSelects selects;
    logic      agnusReq;
    logic      eClock;

    testEntry stimTable[$];
    int       cycleCount   = 0;
    int       cycleLimit   = 100;
    int       ackDelay     = 1;
    int       currentEntry = 0;
    int       ePhase       = 0;

    busCycleTop UUT (
        .bClk, .reset, .ts, .request, .agnusAck,
        .ta, .tea, .selects, .agnusReq, .eClock
    );

    // 100 MHz bus clock
    always #5 bClk = ~bClk;

    always @(posedge bClk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1, "Stopped at table entry %0d", currentEntry);
    endtask

    `include "busCycleChecks.svh"

    // Watchdog for a cycle that never terminates
    always @(posedge bClk) begin
        if (cycleCount >= cycleLimit) begin
            $display("Run hung waiting for bus cycle termination after %0d cycles", cycleCount);
            abortRun();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // E clock reference
    ////////////////////////////////////////////////////////////////////////////

    // Counter starts at zero out of reset, period E_DIVIDE
    always @(posedge bClk) begin
        if (reset) begin
            ePhase <= 0;
        end else begin
            ePhase <= (ePhase + 1) % E_DIVIDE;
        end
    end

    // High from E_HIGH_START to the end of the period
    always @(negedge bClk) begin
        if (!reset) begin
            checkEClock(ePhase >= E_HIGH_START, eClock);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Agnus responder
    ////////////////////////////////////////////////////////////////////////////

    // Ack comes ackDelay cycles after agnusReq rises
    initial begin
        forever begin
            @(negedge bClk);
            if (!reset && agnusReq) begin
                repeat (ackDelay - 1) begin
                    @(posedge bClk);
                end
                @(posedge bClk);
                agnusAck <= 1'b1;
                @(posedge bClk);
                agnusAck <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    function automatic busRequest makeRequest(input logic [31:0] byteAddress,
                                              input transferType tt, input transferMod tm,
                                              input logic write, input logic [7:0] data);
        busRequest req;
        // Word address A31:A1
        req.address = byteAddress[31:1];
        req.tt      = tt;
        req.tm      = tm;
        req.write   = write;
        req.data    = data;
        return req;
    endfunction

    // Arguments say which strobes are asserted
    function automatic busSelects makeSelects(input logic romOn, input logic cs0On,
                                              input logic cs1On, input logic ramOn,
                                              input logic regOn);
        busSelects sel;
        sel.romEn     = romOn;
        sel.ciaCs0n   = !cs0On;
        sel.ciaCs1n   = !cs1On;
        sel.ramSpacen = !ramOn;
        sel.regSpacen = !regOn;
        return sel;
    endfunction

    function automatic void addEntry(input busRequest req, input termKind term,
                                     input busSelects sel, input int latency);
        testEntry entry;
        entry.request    = req;
        entry.expTerm    = term;
        entry.expSelects = sel;
        entry.expLatency = latency;
        stimTable.push_back(entry);
    endfunction

    function automatic void buildTable();
        // Reset vector read from ROM under the overlay
        addEntry(makeRequest(32'h0000_0000, TT_NORMAL, TM_CODE, 0, 8'h00),
                 TERM_ACK, makeSelects(1, 0, 0, 0, 0), ROM_WAIT);
        // CIA-A port A write with OVL low
        addEntry(makeRequest(32'h00BF_E001, TT_NORMAL, TM_DATA, 1, 8'hFE),
                 TERM_ACK, makeSelects(0, 1, 0, 0, 0), LAT_CIA);
        // Same read now goes to chip RAM
        addEntry(makeRequest(32'h0000_0000, TT_NORMAL, TM_CODE, 0, 8'h00),
                 TERM_ACK, makeSelects(0, 0, 0, 1, 0), LAT_AGNUS);
        // High ROM in code and data space
        addEntry(makeRequest(32'h00F8_0000, TT_NORMAL, TM_CODE, 0, 8'h00),
                 TERM_ACK, makeSelects(1, 0, 0, 0, 0), ROM_WAIT);
        addEntry(makeRequest(32'h00F8_0000, TT_NORMAL, TM_DATA, 0, 8'h00),
                 TERM_ACK, makeSelects(1, 0, 0, 0, 0), ROM_WAIT);
        // CIA-A on A12 low and CIA-B on A13 low
        addEntry(makeRequest(32'h00BF_E101, TT_NORMAL, TM_DATA, 0, 8'h00),
                 TERM_ACK, makeSelects(0, 1, 0, 0, 0), LAT_CIA);
        addEntry(makeRequest(32'h00BF_D000, TT_NORMAL, TM_DATA, 0, 8'h00),
                 TERM_ACK, makeSelects(0, 0, 1, 0, 0), LAT_CIA);
        // Code fetch from the CIA bank is unmapped
        addEntry(makeRequest(32'h00BF_E001, TT_NORMAL, TM_CODE, 0, 8'h00),
                 TERM_ERROR, makeSelects(0, 0, 0, 0, 0), BUS_TIMEOUT);
        // Agnus register read and write
        addEntry(makeRequest(32'h00DF_F006, TT_NORMAL, TM_DATA, 0, 8'h00),
                 TERM_ACK, makeSelects(0, 0, 0, 0, 1), LAT_AGNUS);
        addEntry(makeRequest(32'h00DF_F180, TT_NORMAL, TM_DATA, 1, 8'h5A),
                 TERM_ACK, makeSelects(0, 0, 0, 0, 1), LAT_AGNUS);
        // Autovectored interrupt acknowledge
        addEntry(makeRequest(32'hFFFF_FFF3, TT_INT_ACK, TM_DATA, 0, 8'h00),
                 TERM_ACK, makeSelects(0, 0, 0, 0, 0), 1);
        // MMU table scans to ROM and RAM
        addEntry(makeRequest(32'h00F8_0000, TT_NORMAL, TM_SCAN_LOW, 0, 8'h00),
                 TERM_ERROR, makeSelects(0, 0, 0, 0, 0), BUS_TIMEOUT);
        addEntry(makeRequest(32'h0000_0000, TT_NORMAL, TM_SCAN_HIGH, 0, 8'h00),
                 TERM_ERROR, makeSelects(0, 0, 0, 0, 0), BUS_TIMEOUT);
        // Outside the Zorro II top byte
        addEntry(makeRequest(32'h0100_0000, TT_NORMAL, TM_DATA, 0, 8'h00),
                 TERM_ERROR, makeSelects(0, 0, 0, 0, 0), BUS_TIMEOUT);
        addEntry(makeRequest(32'h8000_0004, TT_NORMAL, TM_CODE, 0, 8'h00),
                 TERM_ERROR, makeSelects(0, 0, 0, 0, 0), BUS_TIMEOUT);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // One bus cycle
    ////////////////////////////////////////////////////////////////////////////

    task automatic runEntry(input testEntry entry);
        int        startCycle;
        int        ackCycle;
        int        latency;
        logic      reqSeen;
        logic      finished;
        busSelects seen;
        termKind   observed;

        ackCycle = -1;
        reqSeen  = 1'b0;
        finished = 1'b0;
        seen     = makeSelects(0, 0, 0, 0, 0);

        // ts for exactly one cycle
        @(posedge bClk);
        ts      <= 1'b1;
        request <= entry.request;
        @(negedge bClk);
        startCycle = cycleCount;

        // Bus quiet before ts is taken
        if (ta || tea || agnusReq) begin
            $display("Entry %0d found ta, tea or agnusReq active before ts", currentEntry);
            abortRun();
        end
        checkSelects(makeSelects(0, 0, 0, 0, 0), selects);

        @(posedge bClk);
        ts      <= 1'b0;
        request <= IDLE_REQUEST;

        // Collect strobes until ta or tea
        while (!finished) begin
            @(negedge bClk);
            seen.romEn     = seen.romEn | selects.romEn;
            seen.ciaCs0n   = seen.ciaCs0n & selects.ciaCs0n;
            seen.ciaCs1n   = seen.ciaCs1n & selects.ciaCs1n;
            seen.ramSpacen = seen.ramSpacen & selects.ramSpacen;
            seen.regSpacen = seen.regSpacen & selects.regSpacen;
            // CIA strobes belong inside the high phase of E
            if ((!selects.ciaCs0n || !selects.ciaCs1n) && !eClock) begin
                $display("Entry %0d asserted a CIA chip select while E was low",
                         currentEntry);
                abortRun();
            end
            if (agnusReq) begin
                reqSeen = 1'b1;
            end
            if (agnusAck) begin
                ackCycle = cycleCount;
            end
            finished = ta || tea;
        end
        latency = cycleCount - startCycle;

        if (ta && tea) begin
            $display("Entry %0d asserted ta and tea in the same cycle", currentEntry);
            abortRun();
        end
        observed = ta ? TERM_ACK : TERM_ERROR;
        checkTerm(entry.expTerm, observed);
        checkSelects(entry.expSelects, seen);

        // agnusReq only for chip RAM and register cycles
        if (reqSeen != (entry.expLatency == LAT_AGNUS)) begin
            $display("Entry %0d raised agnusReq on the wrong kind of cycle", currentEntry);
            abortRun();
        end
        if (entry.expLatency == LAT_CIA) begin
            checkLatencyWindow(CIA_MIN, CIA_MAX, latency);
        end else if (entry.expLatency == LAT_AGNUS) begin
            if (ackCycle < 0) begin
                $display("Entry %0d ended before agnusAck was given", currentEntry);
                abortRun();
            end
            // ta one cycle after the ack
            checkLatency(ackCycle - startCycle + 1, latency);
        end else begin
            checkLatency(entry.expLatency, latency);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(2828));
        reset    = 1'b1;
        ts       = 1'b0;
        request  = IDLE_REQUEST;
        agnusAck = 1'b0;
        buildTable();
        cycleLimit = stimTable.size() * 24 + 100;

        repeat (8) begin
            @(posedge bClk);
        end
        reset <= 1'b0;

        foreach (stimTable[i]) begin
            currentEntry = i;
            ackDelay     = $urandom_range(4, 1);
            runEntry(stimTable[i]);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- src/busCycleTop.sv
module busCycleTop (
    input  logic              bClk,
    input  logic              reset,
    input  logic              ts,
    input  busPkg::busRequest request,
    input  logic              agnusAck,
    output logic              ta,
    output logic              tea,
    output mapPkg::busSelects selects,
    output logic              agnusReq,
    output logic              eClock
);
    import busPkg::*;
    import mapPkg::*;

    busRequest heldRequest;
    regionHit  hit;
    logic      ovl;
    logic      ciaEnable;
    logic      ciaStart;
    logic      ciaDone;

    // Request hold and termination
    cycleTerminator terminator (
        .bClk, .reset, .ts, .request, .hit, .ciaDone, .agnusAck,
        .heldRequest, .ciaStart, .agnusReq, .ta, .tea
    );

    // Region decode of the held request
    addressDecode decoder (
        .heldRequest, .ovl, .ciaEnable, .hit, .selects
    );

    // E clock and CIA window
    ciaCycle cia (
        .bClk, .reset, .ciaStart, .ciaEnable, .ciaDone, .eClock
    );

    // Overlay flag, cleared through CIA-A
    overlayControl overlay (
        .bClk, .reset, .heldRequest, .ciaDone, .ovl
    );

endmodule

//--- src/cycleTerminator.sv
module cycleTerminator (
    input  logic              bClk,
    input  logic              reset,
    input  logic              ts,
    input  busPkg::busRequest request,
    input  mapPkg::regionHit  hit,
    input  logic              ciaDone,
    input  logic              agnusAck,
    output busPkg::busRequest heldRequest,
    output logic              ciaStart,
    output logic              agnusReq,
    output logic              ta,
    output logic              tea
);
    import busPkg::*;
    import mapPkg::*;

    typedef enum logic [2:0] {
        idle,
        decode,
        romWait,
        ciaWait,
        agnusWait,
        done
    } cycleState;

    cycleState             state;
    // Cycles since the edge that took ts
    logic [WAIT_WIDTH-1:0] waitCount;
    logic                  agnusHit;
    logic                  noHit;
    logic                  romDone;
    logic                  timedOut;

    assign agnusHit = hit.chipRam || hit.chipReg;
    assign noHit    = hit == '0;
    assign romDone  = waitCount == WAIT_WIDTH'(ROM_WAIT - 1);
    assign timedOut = waitCount == WAIT_WIDTH'(BUS_TIMEOUT - 1);

    ////////////////////////////////////////////////////////////////////////////
    // Handshake outputs
    ////////////////////////////////////////////////////////////////////////////

    // Kick the E window once per CIA cycle
    assign ciaStart = (state == decode) && hit.cia;

    // High from decode through the cycle that sees agnusAck
    assign agnusReq = (state == agnusWait) || ((state == decode) && agnusHit);

    // Autovector ends in decode itself
    // Everything else ends in done
    assign ta  = ((state == decode) && hit.autovector) || ((state == done) && !noHit);
    assign tea = (state == done) && noHit;

    ////////////////////////////////////////////////////////////////////////////
    // Cycle FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge bClk) begin
        if (reset) begin
            state       <= idle;
            waitCount   <= '0;
            heldRequest <= IDLE_REQUEST;
        end else begin
            case (state)
                idle: begin
                    // ts only counts between cycles
                    if (ts) begin
                        heldRequest <= request;
                        waitCount   <= WAIT_WIDTH'(1);
                        state       <= decode;
                    end
                end
                decode: begin
                    waitCount <= waitCount + 1'b1;
                    if (hit.autovector) begin
                        heldRequest <= IDLE_REQUEST;
                        state       <= idle;
                    end else if (hit.rom) begin
                        state <= romWait;
                    end else if (hit.cia) begin
                        state <= ciaWait;
                    end else if (agnusHit) begin
                        state <= agnusAck ? done : agnusWait;
                    end else if (timedOut) begin
                        // Unmapped, tea follows
                        state <= done;
                    end
                end
                romWait: begin
                    waitCount <= waitCount + 1'b1;
                    if (romDone) begin
                        state <= done;
                    end
                end
                ciaWait: begin
                    if (ciaDone) begin
                        state <= done;
                    end
                end
                agnusWait: begin
                    // Only stall point of the bus
                    if (agnusAck) begin
                        state <= done;
                    end
                end
                done: begin
                    // Drop the selects after the ta or tea cycle
                    heldRequest <= IDLE_REQUEST;
                    state       <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- src/ciaCycle.sv
module ciaCycle (
    input  logic bClk,
    input  logic reset,
    input  logic ciaStart,
    output logic ciaEnable,
    output logic ciaDone,
    output logic eClock
);
    import mapPkg::*;

    logic [E_COUNT_WIDTH-1:0] eCount;
    logic                     pending;
    logic                     active;
    logic                     eRise;
    logic                     eLast;
    logic                     launch;

    ////////////////////////////////////////////////////////////////////////////
    // E clock divider
    ////////////////////////////////////////////////////////////////////////////

    // First and last high counts of the period
    assign eRise = eCount == E_COUNT_WIDTH'(E_HIGH_START);
    assign eLast = eCount == E_COUNT_WIDTH'(E_DIVIDE - 1);

    always_ff @(posedge bClk) begin
        if (reset) begin
            eCount <= '0;
            eClock <= 1'b0;
        end else begin
            eCount <= eLast ? '0 : eCount + 1'b1;
            // Registered so the pin is glitch free
            if (eCount == E_COUNT_WIDTH'(E_HIGH_START - 1)) begin
                eClock <= 1'b1;
            end else if (eLast) begin
                eClock <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Access window
    ////////////////////////////////////////////////////////////////////////////

    // Start on this rise if the request lands on it
    assign launch = (pending || ciaStart) && eRise;

    // Covers counts E_HIGH_START through E_DIVIDE-1
    assign ciaEnable = launch || active;

    // Last high cycle, E falls at its end
    assign ciaDone = active && eLast;

    always_ff @(posedge bClk) begin
        if (reset) begin
            pending <= 1'b0;
            active  <= 1'b0;
        end else begin
            // Wait out the rest of the current period
            pending <= (pending || ciaStart) && !eRise;
            active  <= (launch || active) && !eLast;
        end
    end

endmodule

//--- src/overlayControl.sv
module overlayControl (
    input  logic              bClk,
    input  logic              reset,
    input  busPkg::busRequest heldRequest,
    input  logic              ciaDone,
    output logic              ovl
);
    import mapPkg::*;

    logic ovlWrite;

    // Write of 0 to OVL bit of CIA-A port A
    assign ovlWrite = heldRequest.write &&
                      !heldRequest.address.cia.a12 &&
                      (heldRequest.address.cia.regNum == CIA_PRA_REG) &&
                      !heldRequest.data[0];

    // Takes effect when the CIA cycle completes
    always_ff @(posedge bClk) begin
        if (reset) begin
            // ROM mapped at 000000 for the reset vector
            ovl <= 1'b1;
        end else if (ciaDone && ovlWrite) begin
            ovl <= 1'b0;
        end
        // No path sets it again short of reset
    end

endmodule

//--- src/addressDecode.sv
module addressDecode (
    input  busPkg::busRequest heldRequest,
    input  logic              ovl,
    input  logic              ciaEnable,
    output mapPkg::regionHit  hit,
    output mapPkg::busSelects selects
);
    import busPkg::*;
    import mapPkg::*;

    logic       z2Space;
    logic       access;
    logic       dataAccess;
    logic       lowArea;
    logic       hiRom;
    logic [7:0] bank;

    assign bank = heldRequest.address.zorro.bank;

    ////////////////////////////////////////////////////////////////////////////
    // Space and access qualifiers
    ////////////////////////////////////////////////////////////////////////////

    // Only the 16 MB Zorro II window is ours
    assign z2Space = heldRequest.address.zorro.top == Z2_TOP;

    // Code or data, never an MMU table scan
    assign access     = (heldRequest.tm == TM_DATA) || (heldRequest.tm == TM_CODE);
    assign dataAccess = heldRequest.tm == TM_DATA;

    // Low 2 MB and the high ROM banks
    assign lowArea = bank[7:5] == LOW_BANKS;
    assign hiRom   = bank[7:3] == ROM_HI_BANKS;

    ////////////////////////////////////////////////////////////////////////////
    // Region hits
    ////////////////////////////////////////////////////////////////////////////

    // ROM at the reset vector under overlay, and always at F80000
    assign hit.rom = z2Space && access && ((ovl && lowArea) || hiRom);

    // CIAs answer data accesses only
    assign hit.cia = z2Space && dataAccess && (bank == CIA_BANK);

    // Chip RAM shows once the overlay is gone
    assign hit.chipRam = z2Space && access && !ovl && lowArea;

    // Custom chip registers, data space only
    assign hit.chipReg = z2Space && dataAccess && (bank == REG_BANK);

    // IACK cycle, outside any address space
    assign hit.autovector = (heldRequest.tt == TT_INT_ACK) &&
        ({heldRequest.address.zorro.top, bank} == AUTOVECTOR_PAGE);

    ////////////////////////////////////////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////////////////////////////////////////

    assign selects.romEn = hit.rom;

    // CIA-A on A12 low, CIA-B on A13 low, only inside the E window
    assign selects.ciaCs0n = !(ciaEnable && !heldRequest.address.cia.a12);
    assign selects.ciaCs1n = !(ciaEnable && !heldRequest.address.cia.a13);

    // Agnus space strobes
    assign selects.ramSpacen = !hit.chipRam;
    assign selects.regSpacen = !hit.chipReg;

endmodule

//--- src/mapPkg.sv
package mapPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Zorro II address map
    ////////////////////////////////////////////////////////////////////////////

    // A31:A24 of the 16 MB Zorro II space
    localparam logic [7:0]  Z2_TOP          = 8'h00;
    // A23:A21 of the low 2 MB, overlay ROM or chip RAM
    localparam logic [2:0]  LOW_BANKS       = 3'b000;
    // A23:A19 of high ROM at F80000
    localparam logic [4:0]  ROM_HI_BANKS    = 5'b11111;
    localparam logic [7:0]  CIA_BANK        = 8'hBF;
    localparam logic [7:0]  REG_BANK        = 8'hDF;
    // A31:A16 of the interrupt acknowledge page
    localparam logic [15:0] AUTOVECTOR_PAGE = 16'hFFFF;
    // CIA-A port A, holds the OVL bit
    localparam logic [3:0]  CIA_PRA_REG     = 4'h0;

    ////////////////////////////////////////////////////////////////////////////
    // Cycle timing in bClk cycles
    ////////////////////////////////////////////////////////////////////////////

    localparam int ROM_WAIT      = 3;
    localparam int BUS_TIMEOUT   = 16;
    localparam int WAIT_WIDTH    = 5;
    // E clock, low for counts 0 to 5 and high for 6 to 9
    localparam int E_DIVIDE      = 10;
    localparam int E_HIGH_START  = 6;
    localparam int E_COUNT_WIDTH = 4;

    // Decoded regions of the held request
    typedef struct packed {
        logic rom;
        logic cia;
        logic chipRam;
        logic chipReg;
        logic autovector;
    } regionHit;

    // External strobes, n suffix is active low
    typedef struct packed {
        logic romEn;
        logic ciaCs0n;
        logic ciaCs1n;
        logic ramSpacen;
        logic regSpacen;
    } busSelects;

    typedef enum logic [1:0] {TERM_NONE, TERM_ACK, TERM_ERROR} termKind;

endpackage

//--- src/busPkg.sv
package busPkg;

    ////////////////////////////////////////////////////////////////////////////
    // 68040 transfer attributes
    ////////////////////////////////////////////////////////////////////////////

    // TT1:TT0 from the CPU
    typedef logic [1:0] transferType;
    localparam transferType TT_NORMAL  = 2'b00;
    localparam transferType TT_INT_ACK = 2'b11;

    // TM1:TM0, only 01 and 10 are real accesses
    typedef logic [1:0] transferMod;
    localparam transferMod TM_SCAN_LOW  = 2'b00;
    localparam transferMod TM_DATA      = 2'b01;
    localparam transferMod TM_CODE      = 2'b10;
    localparam transferMod TM_SCAN_HIGH = 2'b11;

    ////////////////////////////////////////////////////////////////////////////
    // Word address A31:A1 and its two decodings
    ////////////////////////////////////////////////////////////////////////////

    // Zorro II split into top byte, bank byte and A15:A1
    typedef struct packed {
        logic [7:0]  top;
        logic [7:0]  bank;
        logic [14:0] offset;
    } zorroView;

    // CIA split, A13 and A12 are the chip selects, A11:A8 the register
    typedef struct packed {
        logic [17:0] upper;
        logic        a13;
        logic        a12;
        logic [3:0]  regNum;
        logic [6:0]  lower;
    } ciaView;

    typedef union packed {
        zorroView zorro;
        ciaView   cia;
    } cpuAddress;

    // One CPU bus request, only the low data byte is carried
    typedef struct packed {
        cpuAddress   address;
        transferType tt;
        transferMod  tm;
        logic        write;
        logic [7:0]  data;
    } busRequest;

    // Scan modifier so nothing decodes while the bus is quiet
    localparam busRequest IDLE_REQUEST = '{
        address: '0,
        tt:      TT_NORMAL,
        tm:      TM_SCAN_LOW,
        write:   1'b0,
        data:    8'h00
    };

endpackage
